// File: common/divSqrt_cfg.svh
`ifndef DIVSQRT_CFG_SVH
`define DIVSQRT_CFG_SVH

////////////////////////////////////////
// Digit recurrence
////////////////////////////////////////

// Bits per digit, radix 2
`define LOGR 1
// Digits retired per cycle
`define DIVCOPIES 2
// Result bits per cycle
`define RK (`LOGR * `DIVCOPIES)

////////////////////////////////////////
// Formats
////////////////////////////////////////

// Fraction widths, single and half
`define NF_S 23
`define NF_H 10
// Exponent biases
`define BIAS_S 127
`define BIAS_H 15

// Cycle counter width
`define DURLEN 4
// Quotient or root register width
`define QBITS (`NF_S + 2 + `LOGR)
// Internal signed exponent width
`define EXPW 10

`endif

// File: common/divSqrtPkg.sv
`default_nettype none

`include "divSqrt_cfg.svh"

package divSqrtPkg;

  // One 32-bit operand or result word
  // Decoded as single or as half depending on fmt
  typedef union packed {
    // Single layout
    struct packed {
      logic              sign;
      logic [7:0]        exp;
      logic [`NF_S-1:0]  frac;
    } single;
    // Half layout in the low 16 bits
    struct packed {
      // Zero for half results
      logic [15:0]       pad;
      logic              sign;
      logic [4:0]        exp;
      logic [`NF_H-1:0]  frac;
    } half;
  } fpWordT;

endpackage

`default_nettype wire

// File: hw/divSqrtCycles.sv
`timescale 1ns/100ps
`default_nettype none

`include "divSqrt_cfg.svh"

// Iterations needed for one operation
// ceil(result bits / bits per cycle)
module divSqrtCycles (
  input  logic               fmt,
  input  logic               isSqrt,
  output logic [`DURLEN-1:0] cycles
);

  localparam int DW = `DURLEN;

  // Fraction bits of the chosen format
  int nf;
  // Bits the recurrence must produce
  int resultBits;

  always_comb begin
    // 1 selects single, 0 selects half
    nf = fmt ? `NF_S : `NF_H;

    // Divide needs two guard bits and one integer digit
    // Sqrt root is already in [1,2), guard bits only
    if (isSqrt) begin
      resultBits = nf + 2;
    end else begin
      resultBits = nf + 2 + `LOGR;
    end

    // Ceiling division by RK
    cycles = DW'((resultBits - 1) / `RK + 1);
  end

  // Half divide 7, half sqrt 6
  // Single divide 13, single sqrt 13

endmodule

`default_nettype wire

// File: hw/expPath.sv
`timescale 1ns/100ps
`default_nettype none

`include "divSqrt_cfg.svh"

// Result exponent, worked out beside the digit recurrence
module expPath import divSqrtPkg::*; (
  input  logic                     clk,
  input  logic                     load,
  input  logic                     isSqrt,
  input  logic                     fmt,
  input  fpWordT                   opA,
  input  fpWordT                   opB,
  output logic                     sqrtOdd,
  output logic signed [`EXPW-1:0]  expOut
);

  localparam int EW = `EXPW;
  localparam logic signed [EW-1:0] BIAS_SE = EW'(`BIAS_S);
  localparam logic signed [EW-1:0] BIAS_HE = EW'(`BIAS_H);

  logic signed [EW-1:0] expA, expB, bias;
  // Unbiased A exponent, needed by sqrt
  logic signed [EW-1:0] unbA;
  logic signed [EW-1:0] divExp, sqrtExp;

  always_comb begin
    // Zero-extend the biased fields of the chosen view
    expA = fmt ? {{(EW-8){1'b0}}, opA.single.exp} : {{(EW-5){1'b0}}, opA.half.exp};
    expB = fmt ? {{(EW-8){1'b0}}, opB.single.exp} : {{(EW-5){1'b0}}, opB.half.exp};
    bias = fmt ? BIAS_SE : BIAS_HE;
    unbA = expA - bias;

    // Quotient exponent before normalization
    divExp = expA - expB + bias;
    // floor(e/2) also covers odd e, radicand gets doubled then
    sqrtExp = (unbA >>> 1) + bias;
  end

  // Odd unbiased exponent, iteration aligns the radicand in this cycle
  assign sqrtOdd = isSqrt & unbA[0];

  // Held from load until the next operation
  always_ff @(posedge clk) begin
    if (load) begin
      expOut <= isSqrt ? sqrtExp : divExp;
    end
  end

endmodule

`default_nettype wire

// File: iter/divSqrtIter.sv
`timescale 1ns/100ps
`default_nettype none

`include "divSqrt_cfg.svh"

// Radix-2 restoring recurrence for divide and square root
// DIVCOPIES digits retired per step
module divSqrtIter import divSqrtPkg::*; (
  input  logic               clk,
  input  logic               load,
  input  logic               step,
  input  logic               isSqrt,
  input  logic               fmt,
  input  fpWordT             opA,
  input  fpWordT             opB,
  input  logic               sqrtOdd,
  output logic [`QBITS-1:0]  qBits
);

  // Significand with hidden bit
  localparam int SW = `NF_S + 1;
  // Partial remainder, extra headroom plus a sign bit
  localparam int RW = `QBITS + 4;
  // Radicand, two bits consumed per digit
  localparam int RADW = 2 * `QBITS;

  logic [SW-1:0]   sigA, sigB;
  logic [SW-1:0]   divisorReg;
  logic [RW-1:0]   remReg, remNext;
  logic [RADW-1:0] radReg, radNext;
  logic [`QBITS-1:0] qNext;
  logic            sqrtMode;
  logic [RW-1:0]   diff;
  logic            digit;

  // Half significands sit at the single position
  assign sigA = fmt ? {1'b1, opA.single.frac} :
                      {1'b1, opA.half.frac, {(`NF_S-`NF_H){1'b0}}};
  assign sigB = fmt ? {1'b1, opB.single.frac} :
                      {1'b1, opB.half.frac, {(`NF_S-`NF_H){1'b0}}};

  ////////////////////////////////////////
  // Chained digits of one step
  ////////////////////////////////////////

  always_comb begin
    remNext = remReg;
    radNext = radReg;
    qNext   = qBits;
    diff    = '0;
    digit   = 1'b0;
    for (int i = 0; i < `DIVCOPIES; i++) begin
      if (sqrtMode) begin
        // Bring down the next radicand pair
        remNext = {remNext[RW-3:0], radNext[RADW-1 -: 2]};
        radNext = radNext << 2;
        // Trial is 4*root + 1
        diff    = remNext - {{(RW-`QBITS-2){1'b0}}, qNext, 2'b01};
        digit   = ~diff[RW-1];
        if (digit) begin
          remNext = diff;
        end
      end else begin
        // Remainder stays below twice the divisor
        diff  = remNext - {{(RW-SW){1'b0}}, divisorReg};
        digit = ~diff[RW-1];
        if (digit) begin
          remNext = diff;
        end
        remNext = {remNext[RW-2:0], 1'b0};
      end
      // New digit enters at the bottom
      qNext = {qNext[`QBITS-2:0], digit};
    end
  end

  ////////////////////////////////////////
  // Operand capture and step update
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      sqrtMode   <= isSqrt;
      divisorReg <= sigB;
      // Divide starts from the dividend, sqrt from zero
      remReg     <= isSqrt ? '0 : {{(RW-SW){1'b0}}, sigA};
      // Odd exponent doubles the radicand
      radReg     <= {sigA, {(RADW-SW){1'b0}}} >> (sqrtOdd ? 0 : 1);
      qBits      <= '0;
    end else if (step) begin
      remReg <= remNext;
      radReg <= radNext;
      qBits  <= qNext;
    end
  end

endmodule

`default_nettype wire

// File: iter/divSqrtCtrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "divSqrt_cfg.svh"

// Idle, busy and done sequencer for one operation in flight
module divSqrtCtrl (
  input  logic               clk,
  input  logic               rstN,
  input  logic               inValid,
  output logic               inReady,
  output logic               resValid,
  input  logic               resReady,
  input  logic [`DURLEN-1:0] cycles,
  output logic               load,
  output logic               step,
  output logic               finish
);

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] BUSY = 2'd1;
  localparam logic [1:0] DONE = 2'd2;

  logic [1:0]         state;
  // Steps still to run
  logic [`DURLEN-1:0] cnt;

  // Handshakes straight from the state
  assign inReady  = (state == IDLE);
  assign resValid = (state == DONE);
  assign load     = inValid & inReady;

  // Step while digits remain
  assign step   = (state == BUSY) && (cnt != '0);
  // Last busy cycle, digits complete, pack loads
  assign finish = (state == BUSY) && (cnt == '0);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (load) begin
            state <= BUSY;
            cnt   <= cycles;
          end
        end
        BUSY: begin
          if (finish) begin
            state <= DONE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        // Hold under back-pressure
        DONE: begin
          if (resReady) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/resultPack.sv
`timescale 1ns/100ps
`default_nettype none

`include "divSqrt_cfg.svh"

// Joins digits and exponent into the result word
module resultPack import divSqrtPkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     finish,
  input  logic                     fmtHeld,
  input  logic                     isSqrtHeld,
  input  logic [`QBITS-1:0]        qBits,
  input  logic signed [`EXPW-1:0]  expIn,
  output fpWordT                   result
);

  // Digits produced per operation, RK times the cycle count
  localparam int SDIV  = `RK * ((`NF_S + 2 + `LOGR - 1) / `RK + 1);
  localparam int SSQRT = `RK * ((`NF_S + 2 - 1) / `RK + 1);
  localparam int HDIV  = `RK * ((`NF_H + 2 + `LOGR - 1) / `RK + 1);
  localparam int HSQRT = `RK * ((`NF_H + 2 - 1) / `RK + 1);
  localparam int SHW   = $clog2(`QBITS);

  logic [SHW-1:0]          shAmt;
  logic [`QBITS-1:0]       aligned, norm;
  logic signed [`EXPW-1:0] expAdj;
  fpWordT                  word;

  always_comb begin
    // Left-align so the integer digit lands at the top bit
    case ({fmtHeld, isSqrtHeld})
      2'b11:   shAmt = SHW'(`QBITS - SSQRT);
      2'b10:   shAmt = SHW'(`QBITS - SDIV);
      2'b01:   shAmt = SHW'(`QBITS - HSQRT);
      default: shAmt = SHW'(`QBITS - HDIV);
    endcase
    aligned = qBits << shAmt;

    // Quotient below one needs one more place
    norm   = aligned;
    expAdj = expIn;
    if (!isSqrtHeld && !aligned[`QBITS-1]) begin
      norm   = aligned << 1;
      expAdj = expIn - 1'b1;
    end

    // Truncate below the last fraction bit
    // Sign stays zero, operands are positive
    word = '0;
    if (fmtHeld) begin
      word.single.exp  = expAdj[7:0];
      word.single.frac = norm[`QBITS-2 -: `NF_S];
    end else begin
      word.half.exp  = expAdj[4:0];
      word.half.frac = norm[`QBITS-2 -: `NF_H];
    end
  end

  // Stays put while the result waits to be taken
  always_ff @(posedge clk) begin
    if (!rstN) begin
      result <= '0;
    end else if (finish) begin
      result <= word;
    end
  end

endmodule

`default_nettype wire

// File: hw/divSqrtUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "divSqrt_cfg.svh"

// Iterative divide and square root, half and single
module divSqrtUnit import divSqrtPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  // Operation in
  input  logic    inValid,
  output logic    inReady,
  input  logic    isSqrt,
  input  logic    fmt,
  input  fpWordT  opA,
  input  fpWordT  opB,
  // Result out
  output logic    resValid,
  input  logic    resReady,
  output fpWordT  result
);

  logic [`DURLEN-1:0]      cycles;
  logic                    load, step, finish;
  logic                    sqrtOdd;
  logic [`QBITS-1:0]       qBits;
  logic signed [`EXPW-1:0] expOut;
  // Operation kind for the pack stage
  logic                    fmtHeld, isSqrtHeld;

  always_ff @(posedge clk) begin
    if (load) begin
      fmtHeld    <= fmt;
      isSqrtHeld <= isSqrt;
    end
  end

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  divSqrtCycles i_divSqrtCycles (.fmt, .isSqrt, .cycles);

  divSqrtCtrl i_divSqrtCtrl (
    .clk, .rstN, .inValid, .inReady, .resValid, .resReady,
    .cycles, .load, .step, .finish
  );

  ////////////////////////////////////////
  // Digits and exponent side by side
  ////////////////////////////////////////

  divSqrtIter i_divSqrtIter (
    .clk, .load, .step, .isSqrt, .fmt, .opA, .opB, .sqrtOdd, .qBits
  );

  expPath i_expPath (
    .clk, .load, .isSqrt, .fmt, .opA, .opB, .sqrtOdd, .expOut
  );

  // Combine into the result word
  resultPack i_resultPack (
    .clk, .rstN, .finish, .fmtHeld, .isSqrtHeld, .qBits,
    .expIn(expOut), .result
  );

endmodule

`default_nettype wire

// File: tests/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

// Free-running testbench clock
module clockGen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Half period high, half period low
  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: tests/divSqrtTb.sv
`timescale 1ns/100ps
`default_nettype none

module divSqrtTb;

  logic        clk;
  logic        rstN;
  logic        inValid, inReady;
  logic        isSqrt, fmt;
  logic [31:0] opA, opB;
  logic        resValid, resReady;
  logic [31:0] result;

  // Vectors from the data file
  logic        vSqrt[$];
  logic        vFmt[$];
  logic [31:0] vA[$];
  logic [31:0] vB[$];
  logic [31:0] vExp[$];

  int valueErrs;
  int latencyErrs;
  int protoErrs;
  int cycleCnt;
  // Zero until the vector count is known
  int cycleLimit;

  clockGen #(.PERIOD(40)) i_clockGen (.clk);

  divSqrtUnit i_divSqrtUnit (
    .clk, .rstN, .inValid, .inReady, .isSqrt, .fmt, .opA, .opB,
    .resValid, .resReady, .result
  );

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (cycleLimit != 0 && cycleCnt >= cycleLimit) begin
      $display("Run timed out after %0d cycles without finishing the vectors", cycleCnt);
      $display("Done: errors found");
      $finish;
    end else begin
      cycleCnt++;
    end
  end

  // Iterations from the format and operation
  // ceil(result bits / bits per cycle)
  function automatic int expectedSteps(input logic sqrt, input logic single);
    int nf;
    int bits;
    // Fraction bits of single or half
    nf = single ? 23 : 10;
    // Two guard bits and one integer bit for divide
    bits = sqrt ? nf + 2 : nf + 3;
    // Two result bits per cycle, rounded up
    return (bits + 1) / 2;
  endfunction

  // Step to 2 ns past the next rising edge
  // Inputs change here and outputs are stable
  task automatic nextCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic readVectors();
    int fd;
    int code;
    string line;
    logic [31:0] s, f, a, b, e;
    fd = $fopen("tests/divSqrt_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tests/divSqrt_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // Comment lines and blanks are skipped
        if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
          if ($sscanf(line, "%h %h %h %h %h", s, f, a, b, e) == 5) begin
            vSqrt.push_back(s[0]);
            vFmt.push_back(f[0]);
            vA.push_back(a);
            vB.push_back(b);
            vExp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic runVector(input int idx);
    int gap;
    int hold;
    int k;
    int n;
    logic [31:0] held;
    gap = $urandom_range(3, 0);
    hold = $urandom_range(4, 0);
    n = expectedSteps(vSqrt[idx], vFmt[idx]);

    // No result may come out during the idle gap
    repeat (gap) begin
      nextCycle();
      if (resValid) begin
        $display("Error at %0t: resValid high with no operation in flight", $time);
        protoErrs++;
      end
    end

    isSqrt = vSqrt[idx];
    fmt = vFmt[idx];
    opA = vA[idx];
    opB = vB[idx];
    inValid = 1'b1;
    if (!inReady) begin
      $display("Error at %0t: inReady low while idle, vector %0d", $time, idx);
      protoErrs++;
    end
    nextCycle();

    // Scramble the inputs once the operation is accepted
    inValid = 1'b0;
    opA = $urandom;
    opB = $urandom;
    isSqrt = 1'($urandom_range(1, 0));
    fmt = 1'($urandom_range(1, 0));

    k = 0;
    while (!resValid && k <= 40) begin
      if (inReady) begin
        $display("Error at %0t: inReady high while busy, vector %0d", $time, idx);
        protoErrs++;
      end
      nextCycle();
      k++;
    end
    if (k != n + 1) begin
      $display("Error at %0t: latency %0d, expected %0d, vector %0d", $time, k, n + 1, idx);
      latencyErrs++;
    end

    // Outputs hold while resReady stays low
    held = result;
    repeat (hold) begin
      nextCycle();
      if (!resValid || result != held || inReady) begin
        $display("Error at %0t: output moved under back-pressure, vector %0d", $time, idx);
        protoErrs++;
      end
    end

    if (result != vExp[idx]) begin
      $display("Error at %0t: vector %0d result %h, expected %h",
               $time, idx, result, vExp[idx]);
      valueErrs++;
    end
    if (!vFmt[idx] && result[31:16] != 16'h0) begin
      $display("Error at %0t: half result upper bits %h, vector %0d",
               $time, result[31:16], idx);
      valueErrs++;
    end

    resReady = 1'b1;
    nextCycle();
    resReady = 1'b0;
    if (resValid || !inReady) begin
      $display("Error at %0t: no return to idle after result taken, vector %0d", $time, idx);
      protoErrs++;
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rstN = 1'b0;
    inValid = 1'b0;
    isSqrt = 1'b0;
    fmt = 1'b0;
    opA = '0;
    opB = '0;
    resReady = 1'b0;
    valueErrs = 0;
    latencyErrs = 0;
    protoErrs = 0;
    cycleCnt = 0;
    cycleLimit = 0;
    void'($urandom(32'h614c7101));

    readVectors();
    // Reset cycles on top of the per-vector budget
    cycleLimit = vA.size() * 30 + 5;

    repeat (5) @(posedge clk);
    #2;
    rstN = 1'b1;
    if (resValid || !inReady) begin
      $display("Error at %0t: wrong handshake state after reset", $time);
      protoErrs++;
    end

    if (vA.size() == 0) begin
      $display("The vector file holds no vectors");
      protoErrs++;
    end
    for (int i = 0; i < vA.size(); i++) begin
      runVector(i);
    end

    $display("Vectors %0d, value errors %0d, latency errors %0d, handshake errors %0d",
             vA.size(), valueErrs, latencyErrs, protoErrs);
    if (valueErrs + latencyErrs + protoErrs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/divSqrt_tests.txt
// isSqrt fmt opA opB expected, all hex, fmt 1 is single
// Results truncated toward zero, opB ignored for sqrt
0 0 00004600 00004000 00004200
0 0 00003C00 00004200 00003555
0 0 00004000 00004200 00003955
0 0 00003C00 00003E00 00003955
0 0 00004200 00003C00 00004200
0 0 00003C00 00004700 00003092
1 0 00004400 00001234 00004000
1 0 00004000 0000BEEF 00003DA8
1 0 00004880 00000000 00004200
1 0 00004200 00007777 00003EED
1 0 00003800 00005A5A 000039A8
1 0 00004C00 0000FFFF 00004400
0 1 40C00000 40000000 40400000
0 1 3F800000 40400000 3EAAAAAA
0 1 40000000 40400000 3F2AAAAA
0 1 3F800000 40E00000 3E124924
0 1 40E00000 40000000 40600000
1 1 40800000 DEADBEEF 40000000
1 1 40000000 12345678 3FB504F3
1 1 40400000 00000000 3FDDB3D7
1 1 41100000 CAFE0001 40400000
1 1 3F000000 0F0F0F0F 3F3504F3

// File: compile.f
+incdir+common
common/divSqrtPkg.sv
hw/divSqrtCycles.sv
hw/expPath.sv
iter/divSqrtIter.sv
iter/divSqrtCtrl.sv
hw/resultPack.sv
hw/divSqrtUnit.sv
tests/clockGen.sv
tests/divSqrtTb.sv

// File: run.sh
#!/bin/sh
# Build and run from the project root
verilator --binary -Wno-fatal --top-module divSqrtTb -f compile.f -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  && grep -q "Done: no errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
